// ==== hdl/cpuIsaPkg.sv ====
package cpuIsaPkg;

	parameter int regCount = 16;
	parameter int regSelWidth = 4;
	parameter int opWidth = 5;
	parameter int immWidth = 19;
	parameter int condWidth = 2;

	// opcodes in bits 31..27, gaps left by the dropped mul/div/jal/mfhi/mflo
	parameter logic [opWidth-1:0] opLd = 5'b00000;
	parameter logic [opWidth-1:0] opLdi = 5'b00001;
	parameter logic [opWidth-1:0] opSt = 5'b00010;
	parameter logic [opWidth-1:0] opAdd = 5'b00011;
	parameter logic [opWidth-1:0] opSub = 5'b00100;
	parameter logic [opWidth-1:0] opShr = 5'b00101;
	parameter logic [opWidth-1:0] opShl = 5'b00110;
	parameter logic [opWidth-1:0] opRor = 5'b00111;
	parameter logic [opWidth-1:0] opRol = 5'b01000;
	parameter logic [opWidth-1:0] opAnd = 5'b01001;
	parameter logic [opWidth-1:0] opOr = 5'b01010;
	parameter logic [opWidth-1:0] opAddi = 5'b01011;
	parameter logic [opWidth-1:0] opAndi = 5'b01100;
	parameter logic [opWidth-1:0] opOri = 5'b01101;
	parameter logic [opWidth-1:0] opNeg = 5'b10000;
	parameter logic [opWidth-1:0] opNot = 5'b10001;
	parameter logic [opWidth-1:0] opBr = 5'b10010;
	parameter logic [opWidth-1:0] opJr = 5'b10011;
	parameter logic [opWidth-1:0] opIn = 5'b10101;
	parameter logic [opWidth-1:0] opOut = 5'b10110;
	parameter logic [opWidth-1:0] opNop = 5'b11001;
	parameter logic [opWidth-1:0] opHalt = 5'b11010;

	// branch conditions, taken from the low bits of c2
	parameter logic [condWidth-1:0] condZero = 2'b00;
	parameter logic [condWidth-1:0] condNonZero = 2'b01;
	parameter logic [condWidth-1:0] condPositive = 2'b10;
	parameter logic [condWidth-1:0] condNegative = 2'b11;

	typedef union packed {
		struct packed {
			logic [opWidth-1:0] opcode;
			logic [regSelWidth-1:0] ra;
			logic [regSelWidth-1:0] rb;
			logic [regSelWidth-1:0] rc;
			logic [14:0] spare;
		} rFormat;
		struct packed {
			logic [opWidth-1:0] opcode;
			logic [regSelWidth-1:0] ra;
			logic [regSelWidth-1:0] rb;
			logic [immWidth-1:0] immediate;
		} iFormat;
		struct packed {
			logic [opWidth-1:0] opcode;
			logic [regSelWidth-1:0] ra;
			logic [3:0] c2; // condition sits where rb would be
			logic [immWidth-1:0] offset;
		} bFormat;
	} instructionWord;

endpackage

// ==== hdl/cpuCtrlPkg.sv ====
package cpuCtrlPkg;

	parameter int busSrcWidth = 4;
	parameter int aluOpWidth = 4;
	parameter int stateWidth = 6;
	parameter int stateCount = 20;

	// bus mux sources
	parameter logic [busSrcWidth-1:0] busNone = 4'd0;
	parameter logic [busSrcWidth-1:0] busReg = 4'd1;
	parameter logic [busSrcWidth-1:0] busPc = 4'd2;
	parameter logic [busSrcWidth-1:0] busZ = 4'd3;
	parameter logic [busSrcWidth-1:0] busMdr = 4'd4;
	parameter logic [busSrcWidth-1:0] busInPort = 4'd5;
	parameter logic [busSrcWidth-1:0] busImm = 4'd6;

	parameter logic [aluOpWidth-1:0] aluAdd = 4'd0;
	parameter logic [aluOpWidth-1:0] aluSub = 4'd1;
	parameter logic [aluOpWidth-1:0] aluAnd = 4'd2;
	parameter logic [aluOpWidth-1:0] aluOr = 4'd3;
	parameter logic [aluOpWidth-1:0] aluShr = 4'd4;
	parameter logic [aluOpWidth-1:0] aluShl = 4'd5;
	parameter logic [aluOpWidth-1:0] aluRor = 4'd6;
	parameter logic [aluOpWidth-1:0] aluRol = 4'd7;
	parameter logic [aluOpWidth-1:0] aluNeg = 4'd8;
	parameter logic [aluOpWidth-1:0] aluNot = 4'd9;
	parameter logic [aluOpWidth-1:0] aluIncPc = 4'd10;
	parameter logic [aluOpWidth-1:0] aluPass = 4'd11; // idle value

	// control states, numbered after the execute step they stand for
	parameter logic [stateWidth-1:0] resetState = 6'd0;
	parameter logic [stateWidth-1:0] fetch0 = 6'd1;
	parameter logic [stateWidth-1:0] fetch1 = 6'd2;
	parameter logic [stateWidth-1:0] fetch2 = 6'd3;
	parameter logic [stateWidth-1:0] exec3 = 6'd4;
	parameter logic [stateWidth-1:0] exec4 = 6'd5;
	parameter logic [stateWidth-1:0] exec5 = 6'd6;
	parameter logic [stateWidth-1:0] addr5 = 6'd7;
	parameter logic [stateWidth-1:0] ld6 = 6'd8;
	parameter logic [stateWidth-1:0] ld7 = 6'd9;
	parameter logic [stateWidth-1:0] st6 = 6'd10;
	parameter logic [stateWidth-1:0] st7 = 6'd11;
	parameter logic [stateWidth-1:0] br3 = 6'd12;
	parameter logic [stateWidth-1:0] br4 = 6'd13;
	parameter logic [stateWidth-1:0] br5 = 6'd14;
	parameter logic [stateWidth-1:0] br6 = 6'd15;
	parameter logic [stateWidth-1:0] jr3 = 6'd16;
	parameter logic [stateWidth-1:0] in3 = 6'd17;
	parameter logic [stateWidth-1:0] out3 = 6'd18;
	parameter logic [stateWidth-1:0] haltState = 6'd19;

endpackage

// ==== hdl/controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit (
	input logic Clock,
	input logic Reset,
	input logic Stop,
	input cpuIsaPkg::instructionWord instruction,
	input logic conValue,
	output logic gra, grb, grc,
	output logic rIn, rOut, baOut,
	output logic pcIn, irIn, yIn, zIn,
	output logic marIn, mdrIn, memRead, memWrite,
	output logic conIn, outIn,
	output logic Run,
	output logic [cpuCtrlPkg::busSrcWidth-1:0] busSrc,
	output logic [cpuCtrlPkg::aluOpWidth-1:0] aluOp
);
	import cpuIsaPkg::*;
	import cpuCtrlPkg::*;

	logic [stateWidth-1:0] state;
	logic [stateWidth-1:0] nextState;
	logic [opWidth-1:0] opcode;
	logic baseForm; // ld, ldi, st read rb through baOut
	logic immForm;
	logic unaryForm;
	logic [aluOpWidth-1:0] execAluOp;

	assign opcode = instruction.rFormat.opcode;
	assign baseForm = (opcode == opLd) || (opcode == opLdi) || (opcode == opSt);
	assign immForm = baseForm || (opcode == opAddi) || (opcode == opAndi) || (opcode == opOri);
	assign unaryForm = (opcode == opNeg) || (opcode == opNot);

	always_comb begin
		case (opcode)
			opSub: execAluOp = aluSub;
			opAnd, opAndi: execAluOp = aluAnd;
			opOr, opOri: execAluOp = aluOr;
			opShr: execAluOp = aluShr;
			opShl: execAluOp = aluShl;
			opRor: execAluOp = aluRor;
			opRol: execAluOp = aluRol;
			opNeg: execAluOp = aluNeg;
			opNot: execAluOp = aluNot;
			default: execAluOp = aluAdd; // add, addi and address forms
		endcase
	end

	always_ff @(posedge Clock or posedge Reset) begin
		if (Reset)
			state <= resetState;
		else
			state <= nextState;
	end

	always_comb begin
		case (state)
			resetState: nextState = fetch0;
			fetch0: nextState = Stop ? haltState : fetch1; // stop only at a boundary
			fetch1: nextState = fetch2;
			fetch2: begin
				case (opcode)
					opAdd, opSub, opAnd, opOr, opShr, opShl, opRor, opRol,
					opNeg, opNot, opAddi, opAndi, opOri, opLd, opLdi, opSt:
						nextState = exec3;
					opBr: nextState = br3;
					opJr: nextState = jr3;
					opIn: nextState = in3;
					opOut: nextState = out3;
					opNop: nextState = fetch0;
					opHalt: nextState = haltState;
					default: nextState = fetch0; // unknown codes act as nop
				endcase
			end
			exec3: nextState = exec4;
			exec4: nextState = (opcode == opLd || opcode == opSt) ? addr5 : exec5;
			addr5: nextState = (opcode == opLd) ? ld6 : st6;
			ld6: nextState = ld7;
			st6: nextState = st7;
			br3: nextState = br4;
			br4: nextState = br5;
			br5: nextState = br6;
			haltState: nextState = haltState;
			default: nextState = fetch0;
		endcase
	end

	// one set of strobes per state
	always_comb begin
		{gra, grb, grc, rIn, rOut, baOut} = '0;
		{pcIn, irIn, yIn, zIn, marIn, mdrIn} = '0;
		{memRead, memWrite, conIn, outIn} = '0;
		busSrc = busNone;
		aluOp = aluPass;
		Run = (state != haltState);
		case (state)
			fetch0: begin
				busSrc = busPc;
				marIn = 1'b1;
				aluOp = aluIncPc;
				zIn = 1'b1;
			end
			fetch1: begin
				busSrc = busZ;
				pcIn = 1'b1;
				memRead = 1'b1;
				mdrIn = 1'b1;
			end
			fetch2: begin
				busSrc = busMdr;
				irIn = 1'b1;
			end
			exec3: begin
				busSrc = busReg;
				grb = 1'b1;
				baOut = baseForm;
				rOut = !baseForm;
				yIn = 1'b1;
			end
			exec4: begin
				aluOp = execAluOp;
				zIn = 1'b1;
				if (immForm) begin
					busSrc = busImm;
				end else if (!unaryForm) begin
					busSrc = busReg;
					grc = 1'b1;
					rOut = 1'b1;
				end
			end
			exec5, ld7, in3: begin
				gra = 1'b1;
				rIn = 1'b1;
				busSrc = (state == exec5) ? busZ : (state == ld7) ? busMdr : busInPort;
			end
			addr5: begin
				busSrc = busZ;
				marIn = 1'b1;
			end
			ld6: begin
				memRead = 1'b1;
				mdrIn = 1'b1;
			end
			st6, br3, jr3, out3: begin
				busSrc = busReg;
				gra = 1'b1;
				rOut = 1'b1;
				mdrIn = (state == st6);
				conIn = (state == br3);
				pcIn = (state == jr3);
				outIn = (state == out3);
			end
			st7: memWrite = 1'b1;
			br4: begin
				busSrc = busPc;
				yIn = 1'b1;
			end
			br5: begin
				busSrc = busImm;
				aluOp = aluAdd;
				zIn = 1'b1;
			end
			br6: begin
				busSrc = busZ;
				pcIn = conValue; // taken only when CON was set in br3
			end
			default: ;
		endcase
	end

	memExclusive: assert property (@(posedge Clock) disable iff (Reset)
		!(memRead && memWrite));
	regDirection: assert property (@(posedge Clock) disable iff (Reset)
		!(rIn && rOut));
	legalState: assert property (@(posedge Clock) disable iff (Reset)
		state < stateCount);

endmodule

// ==== hdl/registerFile.sv ====
`timescale 1ns/1ps

module registerFile (
	input logic Clock,
	input logic Reset,
	input cpuIsaPkg::instructionWord instruction,
	input logic gra, grb, grc,
	input logic rIn, rOut, baOut,
	input logic [31:0] busValue,
	output logic [31:0] regValue
);
	import cpuIsaPkg::*;

	logic [31:0] regs [regCount];
	logic [regSelWidth-1:0] regSel;

	// field select, ra/rb/rc sit at the same bits in every format
	always_comb begin
		regSel = '0;
		if (gra)
			regSel = instruction.rFormat.ra;
		else if (grb)
			regSel = instruction.rFormat.rb;
		else if (grc)
			regSel = instruction.rFormat.rc;
	end

	always_ff @(posedge Clock or posedge Reset) begin
		if (Reset) begin
			for (int i = 0; i < regCount; i++)
				regs[i] <= '0;
		end else if (rIn) begin
			regs[regSel] <= busValue;
		end
	end

	always_comb begin
		if (baOut && regSel == '0)
			regValue = '0; // r0 as base means absolute address
		else if (rOut || baOut)
			regValue = regs[regSel];
		else
			regValue = '0;
	end

	oneField: assert property (@(posedge Clock) disable iff (Reset)
		(rIn || rOut || baOut) |-> $onehot0({gra, grb, grc}));

endmodule

// ==== hdl/aluUnit.sv ====
`timescale 1ns/1ps

module aluUnit (
	input logic [31:0] yValue,
	input logic [31:0] busValue,
	input logic [cpuCtrlPkg::aluOpWidth-1:0] aluOp,
	output logic [31:0] result
);
	import cpuCtrlPkg::*;

	logic [4:0] shiftCount;
	logic [63:0] rotLeft;
	logic [63:0] rotRight;

	assign shiftCount = busValue[4:0];

	// doubled word, so a plain shift leaves the rotate in one half
	assign rotLeft = {yValue, yValue} << shiftCount;
	assign rotRight = {yValue, yValue} >> shiftCount;

	always_comb begin
		case (aluOp)
			aluAdd: result = yValue + busValue;
			aluSub: result = yValue - busValue;
			aluAnd: result = yValue & busValue;
			aluOr: result = yValue | busValue;
			aluShr: result = yValue >> shiftCount; // logical
			aluShl: result = yValue << shiftCount;
			aluRor: result = rotRight[31:0];
			aluRol: result = rotLeft[63:32];
			aluNeg: result = 32'd0 - yValue;
			aluNot: result = ~yValue;
			aluIncPc: result = busValue + 32'd1;
			aluPass: result = busValue;
			default: result = busValue;
		endcase
	end

endmodule

// ==== hdl/memoryInterface.sv ====
`timescale 1ns/1ps

module memoryInterface #(
	parameter int addrWidth = 10
) (
	input logic Clock,
	input logic Reset,
	input logic [31:0] busValue,
	input logic marIn, mdrIn,
	input logic memRead, memWrite,
	input logic loadEnable,
	input logic [addrWidth-1:0] loadAddress,
	input logic [31:0] loadData,
	output logic [31:0] mdrValue
);
	logic [31:0] ram [2**addrWidth];
	logic [addrWidth-1:0] mar;
	logic [31:0] readData;

	assign readData = ram[mar]; // asynchronous read, MDR does the capture

	always_ff @(posedge Clock or posedge Reset) begin
		if (Reset)
			mar <= '0;
		else if (marIn)
			mar <= busValue[addrWidth-1:0];
	end

	always_ff @(posedge Clock) begin
		if (mdrIn)
			mdrValue <= memRead ? readData : busValue;
	end

	// program load only happens while the core sits in reset
	always_ff @(posedge Clock) begin
		if (loadEnable)
			ram[loadAddress] <= loadData;
		else if (memWrite)
			ram[mar] <= mdrValue;
	end

	marInRange: assert property (@(posedge Clock) disable iff (Reset)
		marIn |-> (busValue[31:addrWidth] == '0));

endmodule

// ==== hdl/branchCondition.sv ====
`timescale 1ns/1ps

module branchCondition (
	input logic Clock,
	input logic Reset,
	input cpuIsaPkg::instructionWord instruction,
	input logic [31:0] busValue,
	input logic conIn,
	output logic conValue
);
	import cpuIsaPkg::*;

	logic isZero;
	logic condMet;

	assign isZero = (busValue == '0);

	always_comb begin
		case (instruction.bFormat.c2[condWidth-1:0])
			condZero: condMet = isZero;
			condNonZero: condMet = !isZero;
			condPositive: condMet = !busValue[31] && !isZero; // strictly above zero
			condNegative: condMet = busValue[31];
			default: condMet = 1'b0;
		endcase
	end

	always_ff @(posedge Clock or posedge Reset) begin
		if (Reset)
			conValue <= 1'b0;
		else if (conIn)
			conValue <= condMet;
	end

endmodule

// ==== hdl/busDatapath.sv ====
`timescale 1ns/1ps

module busDatapath #(
	parameter int addrWidth = 10
) (
	input logic Clock,
	input logic Reset,
	input logic [cpuCtrlPkg::busSrcWidth-1:0] busSrc,
	input logic pcIn, irIn, yIn, zIn, outIn,
	input logic [31:0] regValue,
	input logic [31:0] mdrValue,
	input logic [31:0] aluResult,
	input logic [31:0] InPort,
	output logic [31:0] busValue,
	output logic [31:0] yValue,
	output cpuIsaPkg::instructionWord instruction,
	output logic [31:0] OutPort,
	output logic outStrobe
);
	import cpuIsaPkg::*;
	import cpuCtrlPkg::*;

	logic [addrWidth-1:0] pc;
	instructionWord ir;
	logic [31:0] z;
	logic [31:0] immValue;

	// same bits serve as immediate and branch offset
	assign immValue = {{(32 - immWidth){ir.iFormat.immediate[immWidth-1]}}, ir.iFormat.immediate};

	// word being fetched shows through in fetch2 so dispatch needs no extra cycle
	assign instruction = irIn ? mdrValue : ir;

	always_ff @(posedge Clock or posedge Reset) begin
		if (Reset) begin
			pc <= '0;
			ir <= '0;
			OutPort <= '0;
			outStrobe <= 1'b0;
		end else begin
			if (pcIn)
				pc <= busValue[addrWidth-1:0];
			if (irIn)
				ir <= busValue;
			if (outIn)
				OutPort <= busValue;
			outStrobe <= outIn; // pulse follows the OutPort load
		end
	end

	always_ff @(posedge Clock) begin
		if (yIn)
			yValue <= busValue;
		if (zIn)
			z <= aluResult;
	end

	always_comb begin
		case (busSrc)
			busNone: busValue = '0;
			busReg: busValue = regValue;
			busPc: busValue = {{(32 - addrWidth){1'b0}}, pc};
			busZ: busValue = z;
			busMdr: busValue = mdrValue;
			busInPort: busValue = InPort;
			busImm: busValue = immValue;
			default: busValue = '0;
		endcase
	end

	pcInRange: assert property (@(posedge Clock) disable iff (Reset)
		pcIn |-> (busValue[31:addrWidth] == '0));

endmodule

// ==== hdl/simpleCpu.sv ====
`timescale 1ns/1ps

module simpleCpu #(
	parameter int addrWidth = 10
) (
	input logic Clock,
	input logic Reset,
	input logic Stop,
	input logic [31:0] InPort,
	input logic loadEnable,
	input logic [addrWidth-1:0] loadAddress,
	input logic [31:0] loadData,
	output logic [31:0] OutPort,
	output logic outStrobe,
	output logic Run
);
	import cpuIsaPkg::*;
	import cpuCtrlPkg::*;

	logic gra, grb, grc, rIn, rOut, baOut;
	logic pcIn, irIn, yIn, zIn, outIn;
	logic marIn, mdrIn, memRead, memWrite;
	logic conIn, conValue;
	logic [busSrcWidth-1:0] busSrc;
	logic [aluOpWidth-1:0] aluOp;
	logic [31:0] busValue;
	logic [31:0] regValue;
	logic [31:0] yValue;
	logic [31:0] aluResult;
	logic [31:0] mdrValue;
	instructionWord instruction;

	controlUnit control0 (
		.Clock, .Reset, .Stop, .instruction, .conValue,
		.gra, .grb, .grc, .rIn, .rOut, .baOut,
		.pcIn, .irIn, .yIn, .zIn, .marIn, .mdrIn, .memRead, .memWrite,
		.conIn, .outIn, .Run, .busSrc, .aluOp
	);

	registerFile regs0 (
		.Clock, .Reset, .instruction,
		.gra, .grb, .grc, .rIn, .rOut, .baOut,
		.busValue, .regValue
	);

	aluUnit alu0 (.yValue, .busValue, .aluOp, .result(aluResult));

	memoryInterface #(.addrWidth(addrWidth)) mem0 (
		.Clock, .Reset, .busValue, .marIn, .mdrIn, .memRead, .memWrite,
		.loadEnable, .loadAddress, .loadData, .mdrValue
	);

	branchCondition branch0 (.Clock, .Reset, .instruction, .busValue, .conIn, .conValue);

	busDatapath #(.addrWidth(addrWidth)) data0 (
		.Clock, .Reset, .busSrc, .pcIn, .irIn, .yIn, .zIn, .outIn,
		.regValue, .mdrValue, .aluResult, .InPort,
		.busValue, .yValue, .instruction, .OutPort, .outStrobe
	);

endmodule

// ==== dv/clockGen.sv ====
`timescale 1ns/1ps

module clockGen #(
	parameter int period = 100,
	parameter int resetCycles = 5
) (
	input logic holdReset,
	output logic Clock,
	output logic Reset
);
	logic powerOnReset;

	assign Reset = powerOnReset || holdReset; // held again for every program load

	initial begin
		Clock = 1'b0;
		forever #(period / 2) Clock = ~Clock;
	end

	// released on a falling edge, away from the sampling edge
	initial begin
		powerOnReset = 1'b1;
		repeat (resetCycles) @(negedge Clock);
		powerOnReset = 1'b0;
	end

endmodule

// ==== dv/simpleCpuTb.sv ====
`timescale 1ns/1ps

module simpleCpuTb;
	import cpuIsaPkg::*;

	localparam int addrWidth = 10;
	localparam int memWords = 2 ** addrWidth;
	localparam int maxProgLen = 64;
	localparam int testCount = 6;
	localparam int cyclePeriod = 100;
	// per test: one load cycle and up to eight run cycles per word, plus slack
	localparam int watchdogCycles = testCount * (maxProgLen * 9 + 40) + 10;
	localparam logic [4:0] aluOpcodes [13] = '{opAdd, opSub, opAnd, opOr, opShr, opShl,
		opRor, opRol, opNeg, opNot, opAddi, opAndi, opOri};

	logic Clock;
	logic Reset;
	logic holdReset;
	logic Stop;
	logic [31:0] InPort;
	logic loadEnable;
	logic [addrWidth-1:0] loadAddress;
	logic [31:0] loadData;
	logic [31:0] OutPort;
	logic outStrobe;
	logic Run;

	logic [31:0] progWords[$];
	logic [31:0] inputs[$]; // InPort level seen after n outputs
	logic [31:0] expectedOuts[$];
	logic [31:0] seenOuts[$];
	logic [31:0] modelMem [memWords];
	logic [31:0] modelRegs [regCount];
	int mismatchCount;
	int failureCount;

	clockGen #(.period(cyclePeriod), .resetCycles(5)) clock0 (.holdReset, .Clock, .Reset);

	simpleCpu #(.addrWidth(addrWidth)) dut0 (
		.Clock, .Reset, .Stop, .InPort, .loadEnable, .loadAddress, .loadData,
		.OutPort, .outStrobe, .Run
	);

	function automatic logic [31:0] encodeReg(logic [4:0] op, logic [3:0] ra, logic [3:0] rb,
		logic [3:0] rc);
		return {op, ra, rb, rc, 15'd0};
	endfunction

	// branches use this too, c2 goes where rb would be
	function automatic logic [31:0] encodeImm(logic [4:0] op, logic [3:0] ra, logic [3:0] rb,
		logic [18:0] imm);
		return {op, ra, rb, imm};
	endfunction

	function automatic logic [18:0] randomImm();
		return 19'($urandom());
	endfunction

	function automatic logic [31:0] rotateLeft(logic [31:0] value, int count);
		logic [31:0] word;
		word = value;
		for (int i = 0; i < count; i++)
			word = {word[30:0], word[31]};
		return word;
	endfunction

	function automatic bit conditionHolds(logic [1:0] c2, logic [31:0] value);
		case (c2)
			condZero: return value == 32'd0;
			condNonZero: return value != 32'd0;
			condPositive: return !value[31] && value != 32'd0;
			default: return value[31];
		endcase
	endfunction

	task automatic reportMismatch(string name, string what, logic [31:0] expected,
		logic [31:0] actual);
		$display("[ERROR] %s %s: expected %h, actual %h", name, what, expected, actual);
		mismatchCount++;
	endtask

	// instruction-level reference, one loop pass per instruction
	task automatic runModel();
		logic [addrWidth-1:0] pc;
		logic [31:0] word, imm, base, a, b, addr;
		logic [4:0] op;
		logic [3:0] ra, rb, rc;
		bit halted;
		int steps;
		expectedOuts.delete();
		for (int i = 0; i < regCount; i++)
			modelRegs[i] = '0;
		for (int i = 0; i < memWords; i++)
			modelMem[i] = (i < progWords.size()) ? progWords[i] : 32'd0;
		pc = '0;
		halted = 1'b0;
		steps = 0;
		while (!halted && steps < maxProgLen * 4) begin
			word = modelMem[pc];
			op = word[31:27];
			ra = word[26:23];
			rb = word[22:19];
			rc = word[18:15];
			imm = {{13{word[18]}}, word[18:0]};
			base = (rb == 4'd0) ? 32'd0 : modelRegs[rb]; // r0 as base reads zero
			a = modelRegs[rb];
			b = modelRegs[rc];
			addr = base + imm;
			pc = pc + 1'b1;
			steps++;
			case (op)
				opAdd: modelRegs[ra] = a + b;
				opSub: modelRegs[ra] = a - b;
				opAnd: modelRegs[ra] = a & b;
				opOr: modelRegs[ra] = a | b;
				opShr: modelRegs[ra] = a >> b[4:0];
				opShl: modelRegs[ra] = a << b[4:0];
				opRol: modelRegs[ra] = rotateLeft(a, int'(b[4:0]));
				opRor: modelRegs[ra] = rotateLeft(a, 32 - int'(b[4:0]));
				opNeg: modelRegs[ra] = 32'd0 - a;
				opNot: modelRegs[ra] = ~a;
				opAddi: modelRegs[ra] = a + imm;
				opAndi: modelRegs[ra] = a & imm;
				opOri: modelRegs[ra] = a | imm;
				opLdi: modelRegs[ra] = addr;
				opLd: modelRegs[ra] = modelMem[addr[addrWidth-1:0]];
				opSt: modelMem[addr[addrWidth-1:0]] = modelRegs[ra];
				opBr: begin
					if (conditionHolds(rb[1:0], modelRegs[ra]))
						pc = pc + imm[addrWidth-1:0]; // relative to the next word
				end
				opJr: pc = modelRegs[ra][addrWidth-1:0];
				opIn: modelRegs[ra] = inputs[expectedOuts.size()];
				opOut: expectedOuts.push_back(modelRegs[ra]);
				opHalt: halted = 1'b1;
				default: ;
			endcase
		end
	endtask

	task automatic startProgram();
		progWords.delete();
		inputs.delete();
		repeat (maxProgLen + 1)
			inputs.push_back($urandom());
	endtask

	task automatic buildAluProgram(int opCount);
		logic [4:0] op;
		logic [3:0] ra;
		int pick;
		for (int r = 1; r < regCount; r++)
			progWords.push_back(encodeImm(opLdi, 4'(r), 4'd0, randomImm()));
		for (int i = 0; i < opCount; i++) begin
			pick = $urandom_range(12);
			op = aluOpcodes[pick];
			ra = 4'($urandom_range(15, 1));
			if (op == opAddi || op == opAndi || op == opOri)
				progWords.push_back(encodeImm(op, ra, 4'($urandom()), randomImm()));
			else
				progWords.push_back(encodeReg(op, ra, 4'($urandom()), 4'($urandom())));
			progWords.push_back(encodeReg(opOut, ra, 4'd0, 4'd0));
		end
	endtask

	// data lives above the program, in 512..1023
	task automatic buildMemoryProgram();
		logic [3:0] bases [6];
		logic [18:0] offsets [6];
		progWords.push_back(encodeImm(opLdi, 4'd1, 4'd0, 19'($urandom_range(800, 600))));
		for (int k = 0; k < 6; k++) begin
			bases[k] = ($urandom_range(1) == 1) ? 4'd1 : 4'd0;
			if (bases[k] == 4'd1)
				offsets[k] = 19'(int'($urandom_range(126)) - 63); // either sign
			else
				offsets[k] = 19'($urandom_range(1023, 512)); // absolute
			progWords.push_back(encodeImm(opLdi, 4'(k + 2), 4'd0, randomImm()));
			progWords.push_back(encodeImm(opSt, 4'(k + 2), bases[k], offsets[k]));
		end
		for (int k = 5; k >= 0; k--) begin
			progWords.push_back(encodeImm(opLd, 4'(k + 8), bases[k], offsets[k]));
			progWords.push_back(encodeReg(opOut, 4'(k + 8), 4'd0, 4'd0));
		end
		progWords.push_back(encodeReg(opHalt, 4'd0, 4'd0, 4'd0));
	endtask

	task automatic buildBranchProgram();
		logic [18:0] testValue;
		int target;
		for (int k = 0; k < 8; k++) begin
			case ($urandom_range(3))
				0: testValue = '0;
				1: testValue = 19'($urandom_range(1000, 1));
				2: testValue = 19'(-int'($urandom_range(1000, 1)));
				default: testValue = randomImm();
			endcase
			progWords.push_back(encodeImm(opLdi, 4'd2, 4'd0, 19'(k + 1))); // marker
			progWords.push_back(encodeImm(opLdi, 4'd1, 4'd0, testValue));
			progWords.push_back(encodeImm(opBr, 4'd1, 4'($urandom_range(3)), 19'd1));
			progWords.push_back(encodeReg(opOut, 4'd2, 4'd0, 4'd0)); // skipped when taken
		end
		target = progWords.size() + 6;
		progWords.push_back(encodeImm(opLdi, 4'd3, 4'd0, 19'(target - 4)));
		progWords.push_back(encodeImm(opAddi, 4'd3, 4'd3, 19'd4));
		progWords.push_back(encodeReg(opJr, 4'd3, 4'd0, 4'd0));
		repeat (3)
			progWords.push_back(encodeReg(opOut, 4'd2, 4'd0, 4'd0));
		progWords.push_back(encodeImm(opLdi, 4'd2, 4'd0, 19'h7ffff));
		progWords.push_back(encodeReg(opOut, 4'd2, 4'd0, 4'd0));
		progWords.push_back(encodeReg(opHalt, 4'd0, 4'd0, 4'd0));
	endtask

	task automatic buildInputProgram();
		for (int k = 1; k <= 8; k++) begin
			progWords.push_back(encodeReg(opIn, 4'(k), 4'd0, 4'd0));
			progWords.push_back(encodeReg(opOut, 4'(k), 4'd0, 4'd0));
		end
		progWords.push_back(encodeReg(opAdd, 4'd9, 4'd1, 4'd2));
		progWords.push_back(encodeReg(opOut, 4'd9, 4'd0, 4'd0));
		progWords.push_back(encodeReg(opHalt, 4'd0, 4'd0, 4'd0));
	endtask

	task automatic checkIdle(string name, string phase);
		if (Run !== 1'b1)
			reportMismatch(name, {"Run ", phase}, 32'd1, 32'(Run));
		if (outStrobe !== 1'b0)
			reportMismatch(name, {"outStrobe ", phase}, 32'd0, 32'(outStrobe));
		if (OutPort !== 32'd0)
			reportMismatch(name, {"OutPort ", phase}, 32'd0, OutPort);
	endtask

	// load under reset, run to halt, then compare with the model
	task automatic runTest(string name, int stopAfter);
		int cycles;
		int limit;
		runModel();
		seenOuts.delete();
		limit = progWords.size() * 8 + 20;
		@(negedge Clock);
		holdReset = 1'b1;
		Stop = 1'b0;
		InPort = inputs[0];
		@(negedge Clock);
		checkIdle(name, "under reset");
		for (int i = 0; i < progWords.size(); i++) begin
			loadEnable = 1'b1;
			loadAddress = addrWidth'(i);
			loadData = progWords[i];
			@(negedge Clock);
		end
		loadEnable = 1'b0;
		holdReset = 1'b0;
		@(negedge Clock);
		while (Reset === 1'b1)
			@(negedge Clock);
		checkIdle(name, "after reset");
		cycles = 0;
		while (Run === 1'b1 && cycles < limit) begin
			@(negedge Clock);
			cycles++;
			if (outStrobe === 1'b1) begin
				seenOuts.push_back(OutPort);
				if (seenOuts.size() < inputs.size())
					InPort = inputs[seenOuts.size()];
				if (seenOuts.size() == stopAfter)
					Stop = 1'b1; // sampled by the fetch0 under way
			end
		end
		if (Run !== 1'b0) begin
			$display("%s: CPU still running after %0d cycles, it never halted", name, limit);
			failureCount++;
		end
		repeat (5) begin
			@(negedge Clock);
			if (outStrobe !== 1'b0) begin
				$display("%s: output strobe appeared after the CPU halted", name);
				failureCount++;
			end
		end
		Stop = 1'b0;
		if (stopAfter > 0) begin
			if (seenOuts.size() != stopAfter)
				reportMismatch(name, "outputs before stop", 32'(stopAfter),
					32'(seenOuts.size()));
		end else if (seenOuts.size() != expectedOuts.size()) begin
			reportMismatch(name, "output count", 32'(expectedOuts.size()), 32'(seenOuts.size()));
		end
		for (int i = 0; i < seenOuts.size() && i < expectedOuts.size(); i++) begin
			if (seenOuts[i] !== expectedOuts[i])
				reportMismatch(name, $sformatf("out %0d", i), expectedOuts[i], seenOuts[i]);
		end
	endtask

	initial begin
		#(watchdogCycles * cyclePeriod);
		$display("timeout: run went past %0d clock cycles without finishing", watchdogCycles);
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		void'($urandom(32'h4e3dfc1f));
		mismatchCount = 0;
		failureCount = 0;
		holdReset = 1'b1;
		Stop = 1'b0;
		InPort = '0;
		loadEnable = 1'b0;
		loadAddress = '0;
		loadData = '0;

		startProgram();
		buildAluProgram(20);
		progWords.push_back(encodeReg(opHalt, 4'd0, 4'd0, 4'd0));
		runTest("aluOps", 0);

		startProgram();
		buildMemoryProgram();
		runTest("memory", 0);

		startProgram();
		buildBranchProgram();
		runTest("branch", 0);

		startProgram();
		buildInputProgram();
		runTest("inPort", 0);

		// outs placed after halt must never show
		startProgram();
		buildAluProgram(8);
		progWords.push_back(encodeReg(opHalt, 4'd0, 4'd0, 4'd0));
		repeat (4)
			progWords.push_back(encodeReg(opOut, 4'd1, 4'd0, 4'd0));
		runTest("halt", 0);

		startProgram();
		buildAluProgram(20);
		progWords.push_back(encodeReg(opHalt, 4'd0, 4'd0, 4'd0));
		runTest("stop", 5);

		$display("%0d value mismatches, %0d other failures", mismatchCount, failureCount);
		if (mismatchCount == 0 && failureCount == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// ==== simpleCpu.f ====
hdl/cpuIsaPkg.sv
hdl/cpuCtrlPkg.sv
hdl/controlUnit.sv
hdl/registerFile.sv
hdl/aluUnit.sv
hdl/memoryInterface.sv
hdl/branchCondition.sv
hdl/busDatapath.sv
hdl/simpleCpu.sv
dv/clockGen.sv
dv/simpleCpuTb.sv

// ==== Makefile ====
TOOL     := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP      := simpleCpuTb
FILELIST := simpleCpu.f
BUILDDIR := obj_dir
LOG      := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)

run: compile
	./$(BUILDDIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAIL" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILDDIR) $(LOG)
